//--- verilog/gpu_settings.svh
`ifndef GPU_SETTINGS_SVH
`define GPU_SETTINGS_SVH

// hardware resources
`define GPU_NUM_WARPS 8
`define GPU_TASK_DEPTH 256
`define GPU_REG_POOL 32

// task word layout
`define GPU_TASK_VALID_BIT 28
`define GPU_TASK_SWID_LSB 20
`define GPU_TASK_PC_LSB 11
`define GPU_TASK_MASK_LSB 3

// the register count occupies bits 2..0

`endif

//--- verilog/gpu_pkg.sv
`include "gpu_settings.svh"

package gpu_pkg;

	// one kernel task as written by the host loader
	typedef logic [`GPU_TASK_VALID_BIT:0] task_word_t;

	// identifiers
	typedef logic [$clog2(`GPU_NUM_WARPS)-1:0] hw_warp_id_t;
	typedef logic [7:0] sw_warp_id_t;
	typedef logic [$clog2(`GPU_TASK_DEPTH)-1:0] task_idx_t;

	// task fields
	typedef logic [8:0] start_pc_t;
	typedef logic [7:0] active_mask_t;
	typedef logic [2:0] reg_count_t;

	// free pool count, wide enough to hold the full pool
	typedef logic [$clog2(`GPU_REG_POOL):0] reg_units_t;

	typedef enum logic [1:0] {
		TM_WAITING,
		TM_WORKING,
		TM_COMPLETE,
		TM_CLEARING
	} tm_state_t;

endpackage

//--- verilog/free_warp_pool.sv
`timescale 1ns/1ps
`include "gpu_settings.svh"

module free_warp_pool (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 clear,
	input  logic                 pop,
	input  logic                 push,
	input  gpu_pkg::hw_warp_id_t push_id,
	output gpu_pkg::hw_warp_id_t head_id,
	output logic                 empty
);
	import gpu_pkg::*;

	localparam int PTR_W = $clog2(`GPU_NUM_WARPS);

	hw_warp_id_t    ids [`GPU_NUM_WARPS];
	logic [PTR_W:0] rd_ptr;
	logic [PTR_W:0] wr_ptr;

	// the list starts full
	// so the write pointer sits one lap ahead of the read pointer
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_ptr <= '0;
			wr_ptr <= {1'b1, {PTR_W{1'b0}}};
			for (int i = 0; i < `GPU_NUM_WARPS; i++) begin
				ids[i] <= hw_warp_id_t'(i);
			end
		end else if (clear) begin
			rd_ptr <= '0;
			wr_ptr <= {1'b1, {PTR_W{1'b0}}};
			for (int i = 0; i < `GPU_NUM_WARPS; i++) begin
				ids[i] <= hw_warp_id_t'(i);
			end
		end else begin
			// hand out the head id
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// exited warp goes to the tail
			if (push) begin
				ids[wr_ptr[PTR_W-1:0]] <= push_id;
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	assign head_id = ids[rd_ptr[PTR_W-1:0]];

	// equal pointers including the lap bit mean nothing is free
	assign empty = (rd_ptr == wr_ptr);

endmodule

//--- verilog/task_table.sv
`timescale 1ns/1ps
`include "gpu_settings.svh"

module task_table (
	input  logic                clk,
	input  logic                rst,
	input  logic                clear,
	input  logic                write_en,
	input  gpu_pkg::task_word_t write_data,
	input  logic                advance,
	output gpu_pkg::task_word_t head_task,
	output gpu_pkg::task_idx_t  head_idx,
	input  gpu_pkg::task_idx_t  read_idx,
	output gpu_pkg::task_word_t read_task,
	input  logic                invalidate,
	output logic                full
);
	import gpu_pkg::*;

	localparam int IDX_W  = $bits(task_idx_t);
	localparam int BODY_W = `GPU_TASK_VALID_BIT;

	// valid bit is the top bit of a task word
	// it is kept apart from the rest of the entry
	logic [BODY_W-1:0]          body [`GPU_TASK_DEPTH];
	logic [`GPU_TASK_DEPTH-1:0] valid;

	logic [IDX_W:0] wr_ptr;
	logic [IDX_W:0] rd_ptr;
	task_idx_t      wr_idx;

	assign wr_idx   = wr_ptr[IDX_W-1:0];
	assign head_idx = rd_ptr[IDX_W-1:0];

	// pointers and valid bits
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			valid  <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			valid  <= '0;
		end else begin
			if (write_en) begin
				valid[wr_idx] <= write_data[`GPU_TASK_VALID_BIT];
				wr_ptr        <= wr_ptr + 1'b1;
			end
			// head moves on once its task is dispatched
			if (advance) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// an exiting warp retires its entry
			if (invalidate) begin
				valid[read_idx] <= 1'b0;
			end
		end
	end

	// task bodies
	always_ff @(posedge clk) begin
		if (clear) begin
			for (int i = 0; i < `GPU_TASK_DEPTH; i++) begin
				body[i] <= '0;
			end
		end else if (write_en) begin
			body[wr_idx] <= write_data[BODY_W-1:0];
		end
	end

	// head read for dispatch
	assign head_task = {valid[head_idx], body[head_idx]};

	// indexed read for the exiting task
	assign read_task = {valid[read_idx], body[read_idx]};

	// same slot, different lap
	assign full = (wr_idx == head_idx) && (wr_ptr[IDX_W] != rd_ptr[IDX_W]);

endmodule

//--- verilog/reg_budget.sv
`timescale 1ns/1ps
`include "gpu_settings.svh"

module reg_budget (
	input  logic                clk,
	input  logic                rst,
	input  logic                clear,
	input  gpu_pkg::reg_count_t head_nreg,
	input  gpu_pkg::reg_count_t exit_nreg,
	input  logic                alloc,
	input  logic                release_en,
	output logic                admit
);
	import gpu_pkg::*;

	reg_units_t free_units;
	reg_units_t head_cost;
	reg_units_t exit_cost;
	reg_units_t units_taken;
	reg_units_t units_back;

	// odd counts round up by one, even counts take two extra
	function automatic reg_units_t cost_of(input reg_count_t count);
		reg_units_t base;
		base = reg_units_t'(count);
		return count[0] ? base + 1'b1 : base + 2'd2;
	endfunction

	assign head_cost = cost_of(head_nreg);
	assign exit_cost = cost_of(exit_nreg);

	// full cost must fit in what is left
	assign admit = (free_units >= head_cost);

	assign units_taken = alloc ? head_cost : '0;
	assign units_back  = release_en ? exit_cost : '0;

	// allocation and release may land on the same edge
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			free_units <= reg_units_t'(`GPU_REG_POOL);
		end else if (clear) begin
			free_units <= reg_units_t'(`GPU_REG_POOL);
		end else if (alloc || release_en) begin
			free_units <= free_units - units_taken + units_back;
		end
	end

endmodule

//--- verilog/task_manager.sv
`timescale 1ns/1ps
`include "gpu_settings.svh"

module task_manager (
	input  logic                  clk,
	input  logic                  rst,

	// host file loader
	input  logic                  write_en,
	input  gpu_pkg::task_word_t   write_data,
	input  logic                  start,
	input  logic                  clear,
	output logic                  finished,

	// dispatch to SIMT stack, fetch and register allocator
	output logic                  update_simt,
	output logic                  update_pc,
	output logic                  update_rau,
	output gpu_pkg::hw_warp_id_t  warp_id,
	output gpu_pkg::active_mask_t active_mask,
	output gpu_pkg::start_pc_t    start_pc,
	output gpu_pkg::reg_count_t   nreg,
	output gpu_pkg::hw_warp_id_t  hw_warp_id,
	output gpu_pkg::sw_warp_id_t  sw_warp_id,
	input  logic                  rau_ready,

	// warp exit from issue
	input  logic                  exit,
	input  gpu_pkg::hw_warp_id_t  exit_warp_id
);
	import gpu_pkg::*;

	localparam int CNT_W = $clog2(`GPU_NUM_WARPS) + 1;

	tm_state_t        state;
	task_word_t       head_task;
	task_word_t       exit_task;
	task_idx_t        head_idx;
	task_idx_t        exit_idx;
	reg_count_t       head_nreg;
	reg_count_t       exit_nreg;
	hw_warp_id_t      pool_head;
	logic             pool_empty;
	logic             table_full;
	logic             admit;
	logic             head_valid;
	logic             table_write;
	logic             dispatch;
	logic             exit_fire;
	logic             clearing;
	logic             all_done;
	logic [CNT_W-1:0] active_cnt;

	// table slot held by each hardware warp
	task_idx_t active_map [`GPU_NUM_WARPS];

	assign clearing   = (state == TM_CLEARING);
	assign head_valid = head_task[`GPU_TASK_VALID_BIT];
	assign head_nreg  = head_task[$bits(reg_count_t)-1:0];
	assign exit_nreg  = exit_task[$bits(reg_count_t)-1:0];
	assign exit_idx   = active_map[exit_warp_id];

	// loads only while waiting, and only tasks marked valid
	assign table_write = (state == TM_WAITING) && write_en &&
		write_data[`GPU_TASK_VALID_BIT] && !table_full;

	assign dispatch  = (state == TM_WORKING) && head_valid && !pool_empty &&
		admit && rau_ready;
	assign exit_fire = (state == TM_WORKING) && exit;

	assign all_done = (active_cnt == '0) && !head_valid && !exit;

	task_table u_table (
		.clk        (clk),
		.rst        (rst),
		.clear      (clearing),
		.write_en   (table_write),
		.write_data (write_data),
		.advance    (dispatch),
		.head_task  (head_task),
		.head_idx   (head_idx),
		.read_idx   (exit_idx),
		.read_task  (exit_task),
		.invalidate (exit_fire),
		.full       (table_full)
	);

	free_warp_pool u_pool (
		.clk     (clk),
		.rst     (rst),
		.clear   (clearing),
		.pop     (dispatch),
		.push    (exit_fire),
		.push_id (exit_warp_id),
		.head_id (pool_head),
		.empty   (pool_empty)
	);

	reg_budget u_budget (
		.clk        (clk),
		.rst        (rst),
		.clear      (clearing),
		.head_nreg  (head_nreg),
		.exit_nreg  (exit_nreg),
		.alloc      (dispatch),
		.release_en (exit_fire),
		.admit      (admit)
	);

	// control FSM
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= TM_WAITING;
			finished <= 1'b0;
		end else begin
			case (state)
				TM_WAITING: begin
					if (clear) begin
						state <= TM_CLEARING;
					end else if (start) begin
						state <= TM_WORKING;
					end
				end
				TM_WORKING: begin
					if (all_done) begin
						state    <= TM_COMPLETE;
						finished <= 1'b1;
					end
				end
				TM_COMPLETE: begin
					if (clear) begin
						state    <= TM_CLEARING;
						finished <= 1'b0;
					end
				end
				// one cycle while the submodules re-initialise
				TM_CLEARING: state <= TM_WAITING;
				default:     state <= TM_WAITING;
			endcase
		end
	end

	// tasks currently running on a warp
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			active_cnt <= '0;
		end else if (clearing) begin
			active_cnt <= '0;
		end else if (dispatch && !exit_fire) begin
			active_cnt <= active_cnt + 1'b1;
		end else if (exit_fire && !dispatch) begin
			active_cnt <= active_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch) begin
			active_map[pool_head] <= head_idx;
		end
	end

	// dispatch strobes, one cycle each
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			update_simt <= 1'b0;
			update_pc   <= 1'b0;
			update_rau  <= 1'b0;
		end else begin
			update_simt <= dispatch;
			update_pc   <= dispatch;
			update_rau  <= dispatch;
		end
	end

	// dispatch fields, valid alongside the strobes
	always_ff @(posedge clk) begin
		if (dispatch) begin
			warp_id     <= pool_head;
			hw_warp_id  <= pool_head;
			nreg        <= head_nreg;
			active_mask <= head_task[`GPU_TASK_MASK_LSB +: $bits(active_mask_t)];
			start_pc    <= head_task[`GPU_TASK_PC_LSB +: $bits(start_pc_t)];
			sw_warp_id  <= head_task[`GPU_TASK_SWID_LSB +: $bits(sw_warp_id_t)];
		end
	end

endmodule

//--- dv/task_manager_properties.sv
`timescale 1ns/1ps

module task_manager_properties (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic finished,
	input logic update_simt,
	input logic update_pc,
	input logic update_rau
);

	// count of failed assertions, read by the testbench
	int failures = 0;

	// SIMT, fetch and allocator must see the same dispatch
	a_strobes_equal: assert property (@(posedge clk) disable iff (!rst)
		(update_simt == update_pc) && (update_simt == update_rau))
		else begin
			$error("dispatch strobes differ");
			failures++;
		end

	// completion only once nothing is left to send
	a_finished_no_dispatch: assert property (@(posedge clk) disable iff (!rst)
		!(finished && update_simt))
		else begin
			$error("finished high together with a dispatch strobe");
			failures++;
		end

	// first cycle out of reset must not dispatch
	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(rst) |=> !(update_simt || update_pc || update_rau))
		else begin
			$error("dispatch strobe right after reset");
			failures++;
		end

	a_quiet_after_clear: assert property (@(posedge clk) disable iff (!rst)
		clear |=> !(update_simt || update_pc || update_rau))
		else begin
			$error("dispatch strobe right after clear");
			failures++;
		end

endmodule

bind task_manager task_manager_properties u_props (
	.clk         (clk),
	.rst         (rst),
	.clear       (clear),
	.finished    (finished),
	.update_simt (update_simt),
	.update_pc   (update_pc),
	.update_rau  (update_rau)
);

//--- dv/task_manager_tb.sv
`timescale 1ns/1ps
`include "gpu_settings.svh"

module task_manager_tb;
	import gpu_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_TESTS    = 5;
	localparam int TEST_CYCLES  = 150;
	localparam int MARGIN       = 100;
	localparam int WAIT_LIMIT   = 40;
	localparam int WATCHDOG_NS  =
		(RESET_CYCLES + NUM_TESTS * TEST_CYCLES + MARGIN) * CLK_PERIOD;

	logic         clk;
	logic         rst;
	logic         write_en;
	task_word_t   write_data;
	logic         start;
	logic         clear;
	logic         finished;
	logic         update_simt;
	logic         update_pc;
	logic         update_rau;
	hw_warp_id_t  warp_id;
	active_mask_t active_mask;
	start_pc_t    start_pc;
	reg_count_t   nreg;
	hw_warp_id_t  hw_warp_id;
	sw_warp_id_t  sw_warp_id;
	logic         rau_ready;
	logic         exit;
	hw_warp_id_t  exit_warp_id;

	// reference model state
	task_word_t  exp_tasks [$];
	hw_warp_id_t free_ids [$];
	int          free_regs;
	reg_count_t  warp_nreg [`GPU_NUM_WARPS];
	logic [`GPU_NUM_WARPS-1:0] active_warps;

	logic [31:0] rng;
	int          errors;
	int          assert_seen;
	int          tests_run;
	int          tests_failed;

	task_manager u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// valid task with random fields and the given register count
	function automatic task_word_t random_task(input reg_count_t n);
		task_word_t w;
		rng = xorshift32(rng);
		w = '0;
		w[`GPU_TASK_VALID_BIT] = 1'b1;
		w[`GPU_TASK_SWID_LSB +: 8] = rng[7:0];
		w[`GPU_TASK_PC_LSB +: 9] = rng[16:8];
		w[`GPU_TASK_MASK_LSB +: 8] = rng[24:17];
		w[2:0] = n;
		return w;
	endfunction

	// odd counts add one, even counts add two
	function automatic int cost_units(input reg_count_t n);
		return int'(n) + (n[0] ? 1 : 2);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h (at %0t)", name, got, exp, $time);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("%0t: %s", $time, what);
		errors++;
	endtask

	task automatic reset_model();
		exp_tasks.delete();
		free_ids.delete();
		for (int i = 0; i < `GPU_NUM_WARPS; i++) begin
			free_ids.push_back(hw_warp_id_t'(i));
		end
		free_regs    = `GPU_REG_POOL;
		active_warps = '0;
	endtask

	task automatic write_task(input task_word_t w);
		@(posedge clk);
		write_en   <= 1'b1;
		write_data <= w;
		// dropped words never reach the scoreboard
		if (w[`GPU_TASK_VALID_BIT]) begin
			exp_tasks.push_back(w);
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		write_en <= 1'b0;
		start    <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic pulse_exit(input hw_warp_id_t id);
		@(posedge clk);
		exit         <= 1'b1;
		exit_warp_id <= id;
		free_ids.push_back(id);
		free_regs += cost_units(warp_nreg[id]);
		active_warps[id] = 1'b0;
		@(posedge clk);
		exit <= 1'b0;
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		@(posedge clk);
		reset_model();
	endtask

	// wait for the next strobe and compare it with the model
	task automatic check_dispatch();
		int          waited;
		task_word_t  exp_w;
		hw_warp_id_t exp_id;
		waited = 0;
		@(negedge clk);
		while (!update_simt && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!update_simt) begin
			report_failure("no dispatch arrived within the wait limit");
			return;
		end
		if (exp_tasks.size() == 0 || free_ids.size() == 0) begin
			report_failure("dispatch with no task or no free warp left in the model");
			return;
		end
		exp_w  = exp_tasks.pop_front();
		exp_id = free_ids.pop_front();
		if (free_regs < cost_units(exp_w[2:0])) begin
			report_failure("dispatch while the register pool was too small");
		end
		free_regs -= cost_units(exp_w[2:0]);
		warp_nreg[exp_id] = exp_w[2:0];
		active_warps[exp_id] = 1'b1;
		if (hw_warp_id !== exp_id) report_mismatch("hw_warp_id", hw_warp_id, exp_id);
		if (warp_id !== exp_id) report_mismatch("warp_id", warp_id, exp_id);
		if (sw_warp_id !== exp_w[`GPU_TASK_SWID_LSB +: 8])
			report_mismatch("sw_warp_id", sw_warp_id, exp_w[`GPU_TASK_SWID_LSB +: 8]);
		if (start_pc !== exp_w[`GPU_TASK_PC_LSB +: 9])
			report_mismatch("start_pc", start_pc, exp_w[`GPU_TASK_PC_LSB +: 9]);
		if (active_mask !== exp_w[`GPU_TASK_MASK_LSB +: 8])
			report_mismatch("active_mask", active_mask, exp_w[`GPU_TASK_MASK_LSB +: 8]);
		if (nreg !== exp_w[2:0]) report_mismatch("nreg", nreg, exp_w[2:0]);
		if (!update_pc || !update_rau) report_failure("dispatch strobes out of step");
	endtask

	task automatic expect_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (update_simt) report_failure("unexpected dispatch strobe");
		end
	endtask

	task automatic wait_finished();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!finished && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!finished) report_failure("finished never rose after all warps exited");
	endtask

	// retire every running warp, then re-initialise for the next test
	task automatic drain_and_clear();
		for (int i = 0; i < `GPU_NUM_WARPS; i++) begin
			if (active_warps[i]) pulse_exit(hw_warp_id_t'(i));
		end
		wait_finished();
		pulse_clear();
		@(negedge clk);
		if (finished !== 1'b0) report_mismatch("finished", finished, 0);
	endtask

	task automatic finish_test(input string name, input int err_before);
		// failed assertions in the bound checker count against this test
		errors += u_dut.u_props.failures - assert_seen;
		assert_seen = u_dut.u_props.failures;
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic test_order_fields();
		int err_before;
		err_before = errors;
		for (int i = 0; i < 5; i++) begin
			write_task(random_task(reg_count_t'(i + 1)));
		end
		pulse_start();
		repeat (5) check_dispatch();
		expect_idle(3);
		drain_and_clear();
		finish_test("order_fields", err_before);
	endtask

	task automatic test_warp_reuse();
		int err_before;
		err_before = errors;
		for (int i = 0; i < 9; i++) begin
			write_task(random_task(reg_count_t'(i % 2)));
		end
		pulse_start();
		repeat (8) check_dispatch();
		// ninth task has registers but no warp
		expect_idle(4);
		pulse_exit(3'd5);
		check_dispatch();
		drain_and_clear();
		finish_test("warp_reuse", err_before);
	endtask

	task automatic test_reg_budget();
		int err_before;
		err_before = errors;
		for (int i = 0; i < 4; i++) begin
			write_task(random_task(3'd7));
		end
		write_task(random_task(3'd2));
		pulse_start();
		repeat (4) check_dispatch();
		// fifth task is held until an exit returns registers
		fork
			begin
				repeat (5) @(posedge clk);
				pulse_exit(3'd2);
			end
			check_dispatch();
		join
		drain_and_clear();
		finish_test("reg_budget", err_before);
	endtask

	task automatic test_back_pressure();
		int err_before;
		err_before = errors;
		@(posedge clk);
		rau_ready <= 1'b0;
		write_task(random_task(3'd3));
		write_task(random_task(3'd4));
		pulse_start();
		expect_idle(6);
		@(posedge clk);
		rau_ready <= 1'b1;
		repeat (2) check_dispatch();
		drain_and_clear();
		finish_test("back_pressure", err_before);
	endtask

	task automatic test_completion_clear();
		int         err_before;
		task_word_t dropped;
		err_before = errors;
		dropped = random_task(3'd1);
		dropped[`GPU_TASK_VALID_BIT] = 1'b0;
		write_task(random_task(3'd1));
		write_task(dropped);
		write_task(random_task(3'd2));
		pulse_start();
		repeat (2) check_dispatch();
		expect_idle(3);
		if (finished !== 1'b0) report_mismatch("finished", finished, 0);
		pulse_exit(3'd0);
		expect_idle(3);
		if (finished !== 1'b0) report_mismatch("finished", finished, 0);
		pulse_exit(3'd1);
		wait_finished();
		pulse_clear();
		// fresh load starts again from warp 0
		write_task(random_task(3'd5));
		write_task(random_task(3'd6));
		pulse_start();
		repeat (2) check_dispatch();
		drain_and_clear();
		finish_test("completion_clear", err_before);
	endtask

	initial begin
		rst          = 1'b0;
		write_en     = 1'b0;
		write_data   = '0;
		start        = 1'b0;
		clear        = 1'b0;
		rau_ready    = 1'b1;
		exit         = 1'b0;
		exit_warp_id = '0;
		rng          = 32'haecc_9458;
		errors       = 0;
		assert_seen  = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;
		test_order_fields();
		test_warp_reuse();
		test_reg_budget();
		test_back_pressure();
		test_completion_clear();
		$display("summary: %0d tests run, %0d failed, %0d errors",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+verilog
verilog/gpu_pkg.sv
verilog/free_warp_pool.sv
verilog/task_table.sv
verilog/reg_budget.sv
verilog/task_manager.sv
dv/task_manager_properties.sv
dv/task_manager_tb.sv
